// ==== Bender.yml ====
package:
  name: narrowed_fifo

sources:
  # design sources in compile order
  - verilog/narrow_fifo_pkg.sv
  - verilog/fifo_tracker.sv
  - verilog/word_store.sv
  - verilog/beat_counter.sv
  - verilog/narrowed_fifo.sv

  # testbench, only for simulation
  - target: simulation
    files:
      - sim/tb_narrowed_fifo.sv

// ==== sim/tb_narrowed_fifo.sv ====
module tb_narrowed_fifo
  import narrow_fifo_pkg::*;
();

  timeunit 1ns;
  timeprecision 1ps;

  localparam int depth_lp = 8;

  logic   clk_i;
  logic   reset_i;
  logic   v_i;
  word_u  data_i;
  logic   ready_o;
  logic   v_o;
  slice_t data_o;
  logic   yumi_i;

  // words the DUT has accepted and not yet released with the head at index 0
  word_u  model_q[$];

  // slice of the head word that the sink takes next
  int     beat_idx;

  // set by the last driven cycle when its word was accepted
  logic   accepted;

  int     errors;
  int     timeouts;
  int     seed_val;

  narrowed_fifo #(
    .depth_p (depth_lp)
  ) dut0 (
    .clk_i   (clk_i),
    .reset_i (reset_i),
    .v_i     (v_i),
    .data_i  (data_i),
    .ready_o (ready_o),
    .v_o     (v_o),
    .data_o  (data_o),
    .yumi_i  (yumi_i)
  );

  always #10 clk_i = ~clk_i;

  task automatic check_slice(input slice_t got, input slice_t exp, input string msg);
    if (got !== exp)
    begin
      $display("error at %0t: %s, got %h expected %h", $time, msg, got, exp);
      errors++;
    end
  endtask

  task automatic check_flag(input logic got, input logic exp, input string msg);
    if (got !== exp)
    begin
      $display("error at %0t: %s, got %b expected %b", $time, msg, got, exp);
      errors++;
    end
  endtask

  // slice n of a word sits n slice widths above bit 0
  function automatic slice_t model_slice(input word_u w, input int beat);
    return slice_t'(w.bits >> (beat * SLICE_W));
  endfunction

  function automatic word_u random_word();
    word_u w;
    w.bits = {$urandom(), $urandom()};
    return w;
  endfunction

  // one clock of stimulus driven at the falling edge
  // outputs are sampled first because they only change at the rising edge
  // a requested yumi is dropped while v_o is low
  task automatic drive_cycle(input logic v, input word_u d, input logic y);
    logic take;
    begin
      @(negedge clk_i);
      check_flag(v_o, model_q.size() != 0, "v_o against stored word count");
      check_flag(ready_o, model_q.size() < depth_lp, "ready_o against stored word count");
      take = y & v_o;
      if (take && model_q.size() != 0)
      begin
        check_slice(data_o, model_slice(model_q[0], beat_idx), "slice on data_o");
      end
      accepted = v & ready_o;
      v_i      = v;
      data_i   = d;
      yumi_i   = take;
      if (accepted)
      begin
        model_q.push_back(d);
      end
      // the last slice releases the head word on the coming edge
      if (take && model_q.size() != 0)
      begin
        beat_idx++;
        if (beat_idx == BEATS)
        begin
          beat_idx = 0;
          void'(model_q.pop_front());
        end
      end
    end
  endtask

  task automatic wait_for_valid(input int limit);
    int n;
    begin
      n = 0;
      while (!v_o && n < limit)
      begin
        drive_cycle(1'b0, '0, 1'b0);
        n++;
      end
      if (!v_o)
      begin
        $display("timeout at %0t: v_o did not rise within %0d cycles", $time, limit);
        timeouts++;
      end
    end
  endtask

  // takes every slice until the model holds no word
  task automatic drain_fifo(input int limit);
    int n;
    begin
      n = 0;
      while (model_q.size() != 0 && n < limit)
      begin
        drive_cycle(1'b0, '0, 1'b1);
        n++;
      end
      if (model_q.size() != 0)
      begin
        $display("timeout at %0t: FIFO did not drain within %0d cycles", $time, limit);
        timeouts++;
      end
    end
  endtask

  task automatic reset_values();
    drive_cycle(1'b0, '0, 1'b0);
    check_flag(v_o, 1'b0, "v_o after reset");
    check_flag(ready_o, 1'b1, "ready_o after reset");
  endtask

  task automatic single_word();
    drive_cycle(1'b1, random_word(), 1'b0);
    wait_for_valid(10);
    repeat (BEATS) drive_cycle(1'b0, '0, 1'b1);
    drive_cycle(1'b0, '0, 1'b0);
    check_flag(v_o, 1'b0, "v_o after the last slice");
  endtask

  // the head word stalls on beat 1 while the sink holds off
  task automatic back_pressure();
    int hold_cycles;
    begin
      drive_cycle(1'b1, random_word(), 1'b0);
      wait_for_valid(10);
      drive_cycle(1'b0, '0, 1'b1);
      hold_cycles = 3 + ($urandom % 6);
      repeat (hold_cycles)
      begin
        drive_cycle(1'b0, '0, 1'b0);
        check_slice(data_o, model_slice(model_q[0], beat_idx), "data_o under back-pressure");
        check_flag(v_o, 1'b1, "v_o under back-pressure");
      end
      drain_fifo(20);
    end
  endtask

  task automatic full_then_drain();
    int count;
    int tries;
    begin
      count = 0;
      tries = 0;
      do
      begin
        drive_cycle(1'b1, random_word(), 1'b0);
        if (accepted)
        begin
          count++;
        end
        tries++;
      end
      while (accepted && tries < 2 * depth_lp);
      if (accepted)
      begin
        $display("timeout at %0t: ready_o did not drop while filling", $time);
        timeouts++;
      end
      check_flag(count == depth_lp, 1'b1, $sformatf("accepted %0d words", count));
      check_flag(ready_o, 1'b0, "ready_o when full");
      drain_fifo(100);
    end
  endtask

  // random traffic on both sides also hits the same-slot bypass
  // one word in about eight cycles matches the drain rate,
  // so the FIFO keeps running empty as well as full
  task automatic random_streaming();
    logic v;
    logic y;
    begin
      repeat (400)
      begin
        v = 1'(($urandom % 8) == 0);
        y = 1'($urandom % 2);
        drive_cycle(v, random_word(), y);
      end
      drain_fifo(200);
      drive_cycle(1'b0, '0, 1'b0);
      check_flag(v_o, 1'b0, "v_o after the final drain");
    end
  endtask

  initial
  begin
    seed_val = $urandom(32'hd76d_1f1c);
    errors   = 0;
    timeouts = 0;
    beat_idx = 0;
    accepted = 1'b0;
    clk_i    = 1'b0;
    reset_i  = 1'b1;
    v_i      = 1'b0;
    data_i   = '0;
    yumi_i   = 1'b0;
    repeat (3) @(posedge clk_i);
    @(negedge clk_i);
    reset_i = 1'b0;
    reset_values();
    single_word();
    back_pressure();
    full_then_drain();
    random_streaming();
    $display("errors=%0d timeouts=%0d", errors, timeouts);
    if (errors == 0 && timeouts == 0)
    begin
      $display("TB PASSED");
    end
    else
    begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule

// ==== tb.f ====
verilog/narrow_fifo_pkg.sv
verilog/fifo_tracker.sv
verilog/word_store.sv
verilog/beat_counter.sv
verilog/narrowed_fifo.sv
sim/tb_narrowed_fifo.sv

// ==== verilog/beat_counter.sv ====
module beat_counter
  import narrow_fifo_pkg::*;
(
  input  logic   clk_i,
  input  logic   reset_i,
  input  word_u  word_i,
  input  logic   yumi_i,
  output logic   deq_o,
  output slice_t slice_o
);

  // index of the slice currently offered to the sink
  logic [BEAT_CNT_W-1:0] count_r;
  logic [BEAT_CNT_W-1:0] count_n;

  // the current slice is the final one of its word
  logic                  last_beat;

  assign last_beat = (count_r == BEAT_CNT_W'(BEATS - 1));

  // advance once per consumed slice
  // the wrap is spelled out so the count never depends on BEATS being a power of two
  always_comb
  begin
    count_n = count_r;
    if (yumi_i)
    begin
      if (last_beat)
      begin
        count_n = '0;
      end
      else
      begin
        count_n = count_r + 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
    begin
      count_r <= '0;
    end
    else
    begin
      count_r <= count_n;
    end
  end

  // beats[0] is the least significant slice, so counting up walks lsb to msb
  assign slice_o = word_i.beats[count_r];

  // the word is handed back on the same cycle its last slice is taken,
  // so the next word can be read out on that edge
  assign deq_o   = yumi_i & last_beat;

endmodule

// ==== verilog/fifo_tracker.sv ====
module fifo_tracker
#(
  parameter int depth_p = 8
)
(
  input  logic                       clk_i,
  input  logic                       reset_i,
  input  logic                       v_i,
  input  logic                       deq_i,
  output logic                       ready_o,
  output logic                       v_o,
  output logic                       wr_en_o,
  output logic [$clog2(depth_p)-1:0] wptr_o,
  output logic [$clog2(depth_p)-1:0] rptr_next_o
);

  localparam int ptr_w_lp = $clog2(depth_p);

  logic [ptr_w_lp-1:0] wptr_r;
  logic [ptr_w_lp-1:0] rptr_r;
  logic [ptr_w_lp-1:0] rptr_n;
  logic                last_enq_r;
  logic                equal_ptrs;
  logic                full;
  logic                empty;
  logic                enq;

  // step a pointer by one slot, wrapping at depth_p
  // depth_p need not be a power of two, so the wrap is an explicit compare
  function automatic logic [ptr_w_lp-1:0] ptr_inc(input logic [ptr_w_lp-1:0] ptr);
    return (ptr == ptr_w_lp'(depth_p - 1)) ? '0 : ptr + 1'b1;
  endfunction

  // an accepted word is a write into the store
  assign enq = v_i & ~full;

  // the read pointer is also needed one cycle early by the synchronous store
  assign rptr_n = deq_i ? ptr_inc(rptr_r) : rptr_r;

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
    begin
      wptr_r     <= '0;
      rptr_r     <= '0;
      // reset counts as a dequeue, so equal pointers read as empty
      last_enq_r <= 1'b0;
    end
    else
    begin
      if (enq)
      begin
        wptr_r <= ptr_inc(wptr_r);
      end
      rptr_r <= rptr_n;
      // a simultaneous enqueue and dequeue never leaves the pointers equal,
      // so only a lone operation has to be remembered
      if (enq ^ deq_i)
      begin
        last_enq_r <= enq;
      end
    end
  end

  // equal pointers mean either no word or depth_p words and the last op decides
  assign equal_ptrs  = (wptr_r == rptr_r);
  assign full        = equal_ptrs & last_enq_r;
  assign empty       = equal_ptrs & ~last_enq_r;

  assign ready_o     = ~full;
  assign v_o         = ~empty;
  assign wr_en_o     = enq;
  assign wptr_o      = wptr_r;
  assign rptr_next_o = rptr_n;

endmodule

// ==== verilog/narrow_fifo_pkg.sv ====
package narrow_fifo_pkg;

  // width of one stored word as it arrives on the input side
  localparam int WORD_W = 64;

  // width of one slice handed to the sink per yumi
  localparam int SLICE_W = 16;

  // number of slices that make up one word
  // the word width divides evenly, so no padding slice exists
  localparam int BEATS = WORD_W / SLICE_W;

  // the beat counter only has to reach BEATS-1
  localparam int BEAT_CNT_W = $clog2(BEATS);

  // one narrow output slice
  typedef logic [SLICE_W-1:0] slice_t;

  // one stored word seen two ways
  // the input port and the memory move it around as a flat vector,
  // while the output side picks it apart one slice at a time
  // beats[0] lands on bits[SLICE_W-1:0], so slices go out lsb first
  typedef union packed
  {
    logic [WORD_W-1:0] bits;
    slice_t [BEATS-1:0] beats;
  } word_u;

endpackage

// ==== verilog/narrowed_fifo.sv ====
module narrowed_fifo
  import narrow_fifo_pkg::*;
#(
  parameter int depth_p = 8
)
(
  input  logic   clk_i,
  input  logic   reset_i,
  input  logic   v_i,
  input  word_u  data_i,
  output logic   ready_o,
  output logic   v_o,
  output slice_t data_o,
  input  logic   yumi_i
);

  localparam int ptr_w_lp = $clog2(depth_p);

  // tracker to store
  logic                wr_en;
  logic [ptr_w_lp-1:0] wptr;
  logic [ptr_w_lp-1:0] rptr_next;

  // store to beat counter carries the word at the head of the FIFO
  word_u               head_word;

  // beat counter back to tracker signals that the head word has been fully sent
  logic                deq;

  // pointers and full/empty, which also give the handshake outputs
  fifo_tracker #(
    .depth_p     (depth_p)
  ) tracker0 (
    .clk_i       (clk_i),
    .reset_i     (reset_i),
    .v_i         (v_i),
    .deq_i       (deq),
    .ready_o     (ready_o),
    .v_o         (v_o),
    .wr_en_o     (wr_en),
    .wptr_o      (wptr),
    .rptr_next_o (rptr_next)
  );

  // reads one edge ahead so the head word is ready when v_o rises
  word_store #(
    .depth_p   (depth_p)
  ) store0 (
    .clk_i     (clk_i),
    .wr_en_i   (wr_en),
    .wr_addr_i (wptr),
    .wr_data_i (data_i),
    .rd_addr_i (rptr_next),
    .word_o    (head_word)
  );

  // cuts the head word into slices and releases it after the last one
  beat_counter counter0 (
    .clk_i   (clk_i),
    .reset_i (reset_i),
    .word_i  (head_word),
    .yumi_i  (yumi_i),
    .deq_o   (deq),
    .slice_o (data_o)
  );

endmodule

// ==== verilog/word_store.sv ====
module word_store
  import narrow_fifo_pkg::*;
#(
  parameter int depth_p = 8
)
(
  input  logic                       clk_i,
  input  logic                       wr_en_i,
  input  logic [$clog2(depth_p)-1:0] wr_addr_i,
  input  word_u                      wr_data_i,
  input  logic [$clog2(depth_p)-1:0] rd_addr_i,
  output word_u                      word_o
);

  localparam int ptr_w_lp = $clog2(depth_p);

  // the word slots themselves
  word_u               mem [depth_p];

  // read address as sampled on the last edge
  logic [ptr_w_lp-1:0] rd_addr_r;

  // copy of a word that was written to the slot being read
  word_u               bypass_r;

  // set when this edge writes the slot that is read on the same edge
  logic                same_addr_n;
  logic                same_addr_r;

  // a write and a read of the same slot on one edge would rely on the
  // read-during-write behavior of the array, so that case goes around it
  assign same_addr_n = wr_en_i & (wr_addr_i == rd_addr_i);

  always_ff @(posedge clk_i)
  begin
    if (wr_en_i)
    begin
      mem[wr_addr_i] <= wr_data_i;
    end
  end

  // the array read is skipped on a collision
  // the old address is kept, but its data is never selected
  always_ff @(posedge clk_i)
  begin
    if (!same_addr_n)
    begin
      rd_addr_r <= rd_addr_i;
    end
  end

  // the incoming word is captured here instead and shows up one cycle later,
  // which is the same latency as a normal array read
  always_ff @(posedge clk_i)
  begin
    if (same_addr_n)
    begin
      bypass_r <= wr_data_i;
    end
    same_addr_r <= same_addr_n;
  end

  // this mostly happens when a word goes into an empty FIFO
  assign word_o = same_addr_r ? bypass_r : mem[rd_addr_r];

endmodule
